// File: vga_defs.svh
// 1024x768 timing and picture placement constants; picture must fit inside the active area
`ifndef VGA_DEFS_SVH
`define VGA_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Horizontal timing, in pixels
////////////////////////////////////////////////////////////////////////////

// Visible pixels per line
`define VGA_H_ACTIVE 1024
// Front porch after the active area
`define VGA_H_FP 24
// Sync pulse width
`define VGA_H_SYNC 136
// Full line including back porch
`define VGA_H_TOTAL 1344

////////////////////////////////////////////////////////////////////////////
// Vertical timing, in lines
////////////////////////////////////////////////////////////////////////////

`define VGA_V_ACTIVE 768
`define VGA_V_FP 3
`define VGA_V_SYNC 6
`define VGA_V_TOTAL 806

////////////////////////////////////////////////////////////////////////////
// Picture rectangle and frame colour
////////////////////////////////////////////////////////////////////////////

// Top left corner on screen
`define PICT_XPOS 0
`define PICT_YPOS 500
// Size, at most 256 in each direction for the 8+8 bit address
`define PICT_W 240
`define PICT_H 256
// One pixel frame around the screen edge
`define BORDER_RGB 12'hFFF

`endif

// File: vga_timing_pkg.sv
// Shared VGA bus layout; counts are 12 bits, so totals above 4095 are not supported
`default_nettype none

package vga_timing_pkg;

        ////////////////////////////////////////////////////////////////////////////
        // Bus passed from stage to stage in 40 bits
        ////////////////////////////////////////////////////////////////////////////

        typedef struct packed {
                // Pixel position within the line
                logic [11:0] hcount;
                // Line position within the frame
                logic [11:0] vcount;
                // Horizontal sync is active high here
                logic        hs;
                // Outside the visible pixels of a line
                logic        hblnk;
                // Vertical sync is active high here
                logic        vs;
                // Outside the visible lines of a frame
                logic        vblnk;
                // Colour drawn so far with 4 bits per channel
                logic [11:0] rgb;
        } vga_bus_t;

endpackage

`default_nettype wire

// File: vga_pict_pkg.sv
// Picture types; 12-bit RGB only, picture address is row byte over column byte
`default_nettype none

package vga_pict_pkg;

        // One pixel colour, red in the top nibble
        typedef struct packed {
                logic [3:0] r;
                logic [3:0] g;
                logic [3:0] b;
        } rgb_t;

        ////////////////////////////////////////////////////////////////////////////
        // Host write into the picture buffer, 29 bits
        ////////////////////////////////////////////////////////////////////////////

        typedef struct packed {
                // Write strobe, one pixel per cycle
                logic        en;
                // Row in [15:8], column in [7:0]
                logic [15:0] addr;
                rgb_t        data;
        } pict_wr_t;

        // Overlay behaviour, latched once per frame
        typedef enum logic [1:0] {
                PICT_OPAQUE,
                PICT_KEYED,
                PICT_HIDDEN
        } pict_mode_e;

endpackage

`default_nettype wire

// File: vga_timing.sv
// Free-running 1024x768 timing; syncs are active high and no polarity conversion is done
`default_nettype none

`include "vga_defs.svh"

module vga_timing
        import vga_timing_pkg::*;
(
        input  logic     clk,
        input  logic     rst,
        output vga_bus_t bus
);

        // Wrap points
        localparam logic [11:0] H_LAST = 12'(`VGA_H_TOTAL - 1);
        localparam logic [11:0] V_LAST = 12'(`VGA_V_TOTAL - 1);

        // Blank starts right after the active area
        localparam logic [11:0] H_BLNK_START = 12'(`VGA_H_ACTIVE);
        localparam logic [11:0] V_BLNK_START = 12'(`VGA_V_ACTIVE);

        // Sync windows, both ends inclusive
        localparam logic [11:0] H_SYNC_START = 12'(`VGA_H_ACTIVE + `VGA_H_FP);
        localparam logic [11:0] H_SYNC_END   = 12'(`VGA_H_ACTIVE + `VGA_H_FP + `VGA_H_SYNC - 1);
        localparam logic [11:0] V_SYNC_START = 12'(`VGA_V_ACTIVE + `VGA_V_FP);
        localparam logic [11:0] V_SYNC_END   = 12'(`VGA_V_ACTIVE + `VGA_V_FP + `VGA_V_SYNC - 1);

        logic [11:0] hcount_nxt;
        logic [11:0] vcount_nxt;

        ////////////////////////////////////////////////////////////////////////////
        // Next count
        ////////////////////////////////////////////////////////////////////////////

        always_comb begin
                hcount_nxt = bus.hcount + 12'd1;
                vcount_nxt = bus.vcount;
                // End of line, step the line counter
                if (bus.hcount == H_LAST) begin
                        hcount_nxt = '0;
                        if (bus.vcount == V_LAST)
                                vcount_nxt = '0;
                        else
                                vcount_nxt = bus.vcount + 12'd1;
                end
        end

        // Syncs and blanks decoded from the next count
        // so they line up with the registered count
        always_ff @(posedge clk) begin
                if (rst) begin
                        bus <= '0;
                end else begin
                        bus.hcount <= hcount_nxt;
                        bus.vcount <= vcount_nxt;
                        bus.hblnk  <= hcount_nxt >= H_BLNK_START;
                        bus.hs     <= (hcount_nxt >= H_SYNC_START) && (hcount_nxt <= H_SYNC_END);
                        bus.vblnk  <= vcount_nxt >= V_BLNK_START;
                        bus.vs     <= (vcount_nxt >= V_SYNC_START) && (vcount_nxt <= V_SYNC_END);
                        // Nothing drawn yet
                        bus.rgb    <= '0;
                end
        end

        // Counters never leave the frame
        a_count_range: assert property (@(posedge clk) disable iff (rst)
                (bus.hcount <= H_LAST) && (bus.vcount <= V_LAST))
                else $error("vga_timing count out of range h=%0d v=%0d",
                            bus.hcount, bus.vcount);

endmodule

`default_nettype wire

// File: vga_draw_bg.sv
// Background fill with a one pixel white frame; one cycle latency, bus otherwise unchanged
`default_nettype none

`include "vga_defs.svh"

module vga_draw_bg
        import vga_timing_pkg::*;
        import vga_pict_pkg::*;
(
        input  logic     clk,
        input  logic     rst,
        input  rgb_t     bg_color,
        input  vga_bus_t bus_in,
        output vga_bus_t bus_out
);

        // Last visible pixel and line
        localparam logic [11:0] H_EDGE = 12'(`VGA_H_ACTIVE - 1);
        localparam logic [11:0] V_EDGE = 12'(`VGA_V_ACTIVE - 1);

        logic        on_border;
        logic [11:0] rgb_nxt;

        ////////////////////////////////////////////////////////////////////////////
        // Colour select
        ////////////////////////////////////////////////////////////////////////////

        // Outermost row or column of the visible area
        assign on_border = (bus_in.hcount == '0) || (bus_in.hcount == H_EDGE) ||
                           (bus_in.vcount == '0) || (bus_in.vcount == V_EDGE);

        always_comb begin
                if (bus_in.hblnk || bus_in.vblnk) begin
                        // Black in blanking
                        rgb_nxt = '0;
                end else if (on_border) begin
                        rgb_nxt = `BORDER_RGB;
                end else begin
                        rgb_nxt = bg_color;
                end
        end

        // Output register
        always_ff @(posedge clk) begin
                if (rst) begin
                        bus_out <= '0;
                end else begin
                        bus_out     <= bus_in;
                        // Only the colour changes here
                        bus_out.rgb <= rgb_nxt;
                end
        end

endmodule

`default_nettype wire

// File: vga_pict_buf.sv
// 64K x 12 picture memory, one write port, read data valid one cycle after the address
`default_nettype none

module vga_pict_buf
        import vga_pict_pkg::*;
(
        input  logic        clk,
        input  pict_wr_t    wr,
        input  logic [15:0] rd_addr,
        output rgb_t        rd_data
);

        // Full 8+8 bit address space with columns 240 to 255 unused
        rgb_t mem [0:65535];

        ////////////////////////////////////////////////////////////////////////////
        // Write port
        ////////////////////////////////////////////////////////////////////////////

        // Host strobe writes one pixel per cycle
        always_ff @(posedge clk) begin
                if (wr.en)
                        mem[wr.addr] <= wr.data;
        end

        ////////////////////////////////////////////////////////////////////////////
        // Read port
        ////////////////////////////////////////////////////////////////////////////

        // Registered read maps onto the block RAM output register
        always_ff @(posedge clk) begin
                rd_data <= mem[rd_addr];
        end

        // Host must not store unknown pixels
        a_wr_known: assert property (@(posedge clk)
                wr.en |-> !$isunknown({wr.addr, wr.data}))
                else $error("vga_pict_buf write with unknown addr or data");

endmodule

`default_nettype wire

// File: vga_draw_pict.sv
// Picture overlay with a fixed 2 cycle latency; needs an external buffer with 1 cycle read
`default_nettype none

`include "vga_defs.svh"

module vga_draw_pict
        import vga_timing_pkg::*;
        import vga_pict_pkg::*;
(
        input  logic        clk,
        input  logic        rst,
        input  pict_mode_e  pict_mode,
        input  rgb_t        key_color,
        input  vga_bus_t    bus_in,
        input  rgb_t        rd_data,
        output logic [15:0] rd_addr,
        output vga_bus_t    bus_out
);

        // Picture rectangle in screen coordinates
        localparam logic [11:0] PICT_X0     = 12'(`PICT_XPOS);
        localparam logic [11:0] PICT_Y0     = 12'(`PICT_YPOS);
        localparam logic [11:0] PICT_WIDTH  = 12'(`PICT_W);
        localparam logic [11:0] PICT_HEIGHT = 12'(`PICT_H);

        logic [11:0] rel_x;
        logic [11:0] rel_y;
        logic        hit_in;
        logic        frame_origin;
        vga_bus_t    bus_s1;
        logic        hit_s1;
        pict_mode_e  mode_q;
        rgb_t        key_q;
        logic        show_pict;

        ////////////////////////////////////////////////////////////////////////////
        // Address generation
        ////////////////////////////////////////////////////////////////////////////

        // Position relative to the picture corner
        assign rel_x = bus_in.hcount - PICT_X0;
        assign rel_y = bus_in.vcount - PICT_Y0;

        // Left of or above the corner wraps to a large value
        assign hit_in = (rel_x < PICT_WIDTH) && (rel_y < PICT_HEIGHT);

        // Row byte over column byte
        assign rd_addr = {rel_y[7:0], rel_x[7:0]};

        assign frame_origin = (bus_in.hcount == '0) && (bus_in.vcount == '0);

        // Mode and key only change at the frame origin
        always_ff @(posedge clk) begin
                if (rst)
                        mode_q <= PICT_HIDDEN;
                else if (frame_origin)
                        mode_q <= pict_mode;
        end

        always_ff @(posedge clk) begin
                if (frame_origin)
                        key_q <= key_color;
        end

        // First stage, waits for the memory read
        always_ff @(posedge clk) begin
                if (rst) begin
                        bus_s1 <= '0;
                        hit_s1 <= 1'b0;
                end else begin
                        bus_s1 <= bus_in;
                        hit_s1 <= hit_in;
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // Overlay decision
        ////////////////////////////////////////////////////////////////////////////

        always_comb begin
                show_pict = 1'b0;
                if (hit_s1 && !bus_s1.hblnk && !bus_s1.vblnk) begin
                        case (mode_q)
                                PICT_OPAQUE: show_pict = 1'b1;
                                // Key colour lets the background through
                                PICT_KEYED:  show_pict = rd_data != key_q;
                                default:     show_pict = 1'b0;
                        endcase
                end
        end

        // Output register
        always_ff @(posedge clk) begin
                if (rst) begin
                        bus_out <= '0;
                end else begin
                        bus_out <= bus_s1;
                        if (show_pict)
                                bus_out.rgb <= rd_data;
                end
        end

        // Counts leave exactly two cycles after they enter
        a_latency: assert property (@(posedge clk) disable iff (rst)
                bus_out.hcount == $past(bus_in.hcount, 2))
                else $error("vga_draw_pict latency mismatch");

endmodule

`default_nettype wire

// File: vga_pict_top.sv
// Timing, background and picture chain; vga_out lags the timing registers by 3 cycles
`default_nettype none

module vga_pict_top
        import vga_timing_pkg::*;
        import vga_pict_pkg::*;
(
        input  logic       clk,
        input  logic       rst,
        input  rgb_t       bg_color,
        input  pict_mode_e pict_mode,
        input  rgb_t       key_color,
        input  pict_wr_t   pict_wr,
        output vga_bus_t   vga_out
);

        vga_bus_t    bus_tim;
        vga_bus_t    bus_bg;
        logic [15:0] rd_addr;
        rgb_t        rd_data;

        ////////////////////////////////////////////////////////////////////////////
        // Pipeline stages
        ////////////////////////////////////////////////////////////////////////////

        vga_timing u_tim (
                .clk (clk),
                .rst (rst),
                .bus (bus_tim)
        );

        // One cycle
        vga_draw_bg u_bg (
                .clk      (clk),
                .rst      (rst),
                .bg_color (bg_color),
                .bus_in   (bus_tim),
                .bus_out  (bus_bg)
        );

        // Host loads the picture here, read side owned by u_pict
        vga_pict_buf u_buf (
                .clk     (clk),
                .wr      (pict_wr),
                .rd_addr (rd_addr),
                .rd_data (rd_data)
        );

        // Two cycles
        vga_draw_pict u_pict (
                .clk       (clk),
                .rst       (rst),
                .pict_mode (pict_mode),
                .key_color (key_color),
                .bus_in    (bus_bg),
                .rd_data   (rd_data),
                .rd_addr   (rd_addr),
                .bus_out   (vga_out)
        );

endmodule

`default_nettype wire

// File: tb_vga_pict.sv
// Testbench for vga_pict_top; runs about four frames, so expect a few million clock cycles
`default_nettype none

`include "vga_defs.svh"

module tb_vga_pict
        import vga_timing_pkg::*;
        import vga_pict_pkg::*;
();
        timeunit 1ns;
        timeprecision 1ps;

        localparam int FRAME_CYC = `VGA_H_TOTAL * `VGA_V_TOTAL;

        logic       clk;
        logic       rst;
        rgb_t       bg_color;
        pict_mode_e pict_mode;
        rgb_t       key_color;
        pict_wr_t   pict_wr;
        vga_bus_t   vga_out;

        // Host side copy of the buffer contents
        logic [11:0] pict_copy [0:65535];
        logic [11:0] key_val;

        // Checker state
        logic        rst_d1 = 1'b0;
        logic        rst_d2 = 1'b0;
        pict_mode_e  mode_d1 = PICT_HIDDEN;
        pict_mode_e  mode_d2 = PICT_HIDDEN;
        logic [11:0] key_d1 = '0;
        logic [11:0] key_d2 = '0;
        pict_mode_e  frame_mode = PICT_HIDDEN;
        logic [11:0] frame_key = '0;
        logic        run_chk = 1'b0;
        logic        have_prev = 1'b0;
        int          prev_h;
        int          prev_v;
        int          frames_seen = 0;

        vga_pict_top dut0 (
                .clk       (clk),
                .rst       (rst),
                .bg_color  (bg_color),
                .pict_mode (pict_mode),
                .key_color (key_color),
                .pict_wr   (pict_wr),
                .vga_out   (vga_out)
        );

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        ////////////////////////////////////////////////////////////////////////////
        // Reference and checks
        ////////////////////////////////////////////////////////////////////////////

        task automatic check_val(input string name, input logic [47:0] got,
                                 input logic [47:0] exp);
                if (got !== exp) begin
                        $display("CHECK FAILED %s got %h expected %h at h=%0d v=%0d",
                                 name, got, exp, vga_out.hcount, vga_out.vcount);
                        $display(">>> FAIL");
                        $fatal(1, "stopping at the first mismatch");
                end
        endtask

        // Background first and the overlay on top
        function automatic logic [11:0] expect_rgb(input int h, input int v,
                                                   input pict_mode_e mode);
                logic [11:0] bg;
                logic [11:0] pix;
                int          rx;
                int          ry;
                rx = h - `PICT_XPOS;
                ry = v - `PICT_YPOS;
                if (h >= `VGA_H_ACTIVE || v >= `VGA_V_ACTIVE)
                        return 12'h000;
                if (h == 0 || h == `VGA_H_ACTIVE - 1 || v == 0 || v == `VGA_V_ACTIVE - 1)
                        bg = `BORDER_RGB;
                else
                        bg = bg_color;
                if (rx < 0 || rx >= `PICT_W || ry < 0 || ry >= `PICT_H)
                        return bg;
                // Row byte over column byte
                pix = pict_copy[ry * 256 + rx];
                case (mode)
                        PICT_OPAQUE: return pix;
                        PICT_KEYED:  return (pix != frame_key) ? pix : bg;
                        default:     return bg;
                endcase
        endfunction

        task automatic check_pixel();
                int h;
                int v;
                int exp_h;
                int exp_v;
                h = int'(vga_out.hcount);
                v = int'(vga_out.vcount);
                // Mode in force was latched two cycles before the origin shows here
                if (h == 0 && v == 0) begin
                        frame_mode = mode_d2;
                        frame_key = key_d2;
                        frames_seen++;
                end
                if (have_prev) begin
                        exp_h = (prev_h == `VGA_H_TOTAL - 1) ? 0 : prev_h + 1;
                        exp_v = prev_v;
                        if (prev_h == `VGA_H_TOTAL - 1)
                                exp_v = (prev_v == `VGA_V_TOTAL - 1) ? 0 : prev_v + 1;
                        check_val("hcount", 48'(h), 48'(exp_h));
                        check_val("vcount", 48'(v), 48'(exp_v));
                end
                check_val("hblnk", 48'(vga_out.hblnk), 48'(h >= `VGA_H_ACTIVE));
                check_val("vblnk", 48'(vga_out.vblnk), 48'(v >= `VGA_V_ACTIVE));
                check_val("hs", 48'(vga_out.hs),
                          48'(h >= `VGA_H_ACTIVE + `VGA_H_FP &&
                              h <= `VGA_H_ACTIVE + `VGA_H_FP + `VGA_H_SYNC - 1));
                check_val("vs", 48'(vga_out.vs),
                          48'(v >= `VGA_V_ACTIVE + `VGA_V_FP &&
                              v <= `VGA_V_ACTIVE + `VGA_V_FP + `VGA_V_SYNC - 1));
                check_val("rgb", 48'(vga_out.rgb), 48'(expect_rgb(h, v, frame_mode)));
                prev_h = h;
                prev_v = v;
                have_prev = 1'b1;
        endtask

        // Samples on the rising edge with inputs settled since the falling one
        always @(posedge clk) begin
                // Reset value holds also on the first cycle after release
                if (rst_d1 || rst_d2)
                        check_val("vga_out", 48'(vga_out), 48'(0));
                // Full checks start at the first pixel after the reset copies of (0,0)
                if (!run_chk && !rst && !rst_d1 && vga_out.hcount == 12'd1 &&
                    vga_out.vcount == 12'd0)
                        run_chk = 1'b1;
                if (run_chk)
                        check_pixel();
                rst_d2 = rst_d1;
                rst_d1 = rst;
                mode_d2 = mode_d1;
                mode_d1 = pict_mode;
                key_d2 = key_d1;
                key_d1 = key_color;
        end

        ////////////////////////////////////////////////////////////////////////////
        // Stimulus
        ////////////////////////////////////////////////////////////////////////////

        // Steps at least once so that back to back calls reach the next frame
        task automatic wait_pos(input int h, input int v);
                int n;
                n = 0;
                do begin
                        @(negedge clk);
                        n++;
                        if (n > 2 * FRAME_CYC) begin
                                $display(">>> FAIL");
                                $fatal(1, "timed out waiting for position h=%0d v=%0d", h, v);
                        end
                end while (!(int'(vga_out.hcount) == h && int'(vga_out.vcount) == v));
        endtask

        // About a quarter of all pixels carry the key colour
        task automatic load_picture();
                pict_wr_t w;
                for (int a = 0; a < 65536; a++) begin
                        w.en = 1'b1;
                        w.addr = 16'(a);
                        if ($urandom_range(3) == 0)
                                w.data = key_val;
                        else
                                w.data = 12'($urandom);
                        pict_copy[a] = w.data;
                        @(negedge clk);
                        pict_wr = w;
                end
                @(negedge clk);
                pict_wr = '0;
        endtask

        initial begin
                void'($urandom(35));
                rst = 1'b1;
                bg_color = 12'h25A;
                pict_mode = PICT_HIDDEN;
                key_color = '0;
                pict_wr = '0;
                key_val = 12'($urandom);
                repeat (10) @(negedge clk);
                rst = 1'b0;
                // Frame 0 stays hidden while loading
                load_picture();
                key_color = key_val;
                pict_mode = PICT_OPAQUE;
                // Frame 1 is opaque and a change in mid frame waits for the origin
                wait_pos(0, 0);
                wait_pos(0, 384);
                pict_mode = PICT_KEYED;
                // Frame 2 keyed
                wait_pos(0, 0);
                wait_pos(0, 384);
                pict_mode = PICT_HIDDEN;
                // New key stays out of the picture rows left in frame 2
                key_color = ~key_val;
                // Frame 3 hidden again
                wait_pos(0, 0);
                wait_pos(0, 0);
                if (!run_chk || frames_seen < 3) begin
                        $display(">>> FAIL");
                        $fatal(1, "checker saw too few frames, only %0d", frames_seen);
                end else begin
                        $display(">>> PASS");
                        $finish;
                end
        end

endmodule

`default_nettype wire

// File: vga_pict_top.f
+incdir+.
vga_timing_pkg.sv
vga_pict_pkg.sv
vga_timing.sv
vga_draw_bg.sv
vga_pict_buf.sv
vga_draw_pict.sv
vga_pict_top.sv
tb_vga_pict.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_vga_pict
FILELIST  ?= vga_pict_top.f
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

# The binary exits non-zero on $fatal, so make fails with it
sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
